// ==== source/macro_settings.svh ====
`ifndef MACRO_SETTINGS_SVH
`define MACRO_SETTINGS_SVH

// spin array
`define MACRO_NUM_SPIN 16

// bits per coupling and per bias
`define MACRO_BITJ 4

// coupling rows per weight read
`define MACRO_PARALLELISM 4

`define MACRO_ENERGY_BIT 32

// prefetch buffer entries
`define MACRO_FETCH_DEPTH 2

`define MACRO_FLIP_ADDR_BIT 6
`define MACRO_SCALE_BIT 4

`endif

// ==== source/ising_pkg.sv ====
`default_nettype none

`include "macro_settings.svh"

package ising_pkg;

    // one bit per spin, 1 stands for +1 and 0 for -1
    typedef logic [`MACRO_NUM_SPIN-1:0] spin_t;

    // signed coupling or bias weight
    typedef logic signed [`MACRO_BITJ-1:0] weight_t;

    // element j of a row is J_ij
    typedef weight_t [`MACRO_NUM_SPIN-1:0] j_row_t;

    // rows base*PARALLELISM + r
    typedef j_row_t [`MACRO_PARALLELISM-1:0] j_block_t;

    typedef weight_t [`MACRO_NUM_SPIN-1:0] h_vec_t;

    typedef logic signed [`MACRO_ENERGY_BIT-1:0] energy_t;

    // index of a weight block
    typedef logic [$clog2(`MACRO_NUM_SPIN / `MACRO_PARALLELISM)-1:0] block_addr_t;

endpackage

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

`include "macro_settings.svh"

package mem_pkg;

    import ising_pkg::*;

    typedef logic [`MACRO_FLIP_ADDR_BIT-1:0] flip_addr_t;

    // weight memory read port, data one cycle after ren
    typedef struct packed {
        logic        ren;
        block_addr_t addr;
    } weight_req_t;

    // flip memory read port
    typedef struct packed {
        logic       ren;
        flip_addr_t addr;
    } flip_req_t;

    typedef struct packed {
        spin_t mask;
    } flip_rsp_t;

endpackage

`default_nettype wire

// ==== source/weight_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "macro_settings.svh"

module weight_fetch
    import ising_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        flush_i,
    input  logic        start_i,
    output weight_req_t weight_req_o,
    input  j_block_t    weight_rdata_i,
    output logic        blk_valid_o,
    input  logic        blk_ready_i,
    output j_block_t    blk_o
);

    localparam int num_blocks = `MACRO_NUM_SPIN / `MACRO_PARALLELISM;
    localparam int depth = `MACRO_FETCH_DEPTH;
    localparam int ptr_bit = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bit = $clog2(depth + 1);

    j_block_t           buf_q [depth];
    logic [ptr_bit-1:0] wr_ptr_q;
    logic [ptr_bit-1:0] rd_ptr_q;
    logic [cnt_bit-1:0] count_q;
    logic [cnt_bit:0]   occupancy;
    logic               pending_q;
    logic               fetching_q;
    block_addr_t        blk_cnt_q;
    logic               issue;
    logic               pop;
    logic               push;
    logic               bypass;
    logic               buf_pop;

    // reads in flight plus buffered blocks
    assign occupancy = count_q + pending_q;

    // empty buffer lets returning data straight through
    assign bypass = (count_q == '0);
    assign blk_valid_o = !bypass || pending_q;
    assign blk_o = bypass ? weight_rdata_i : buf_q[rd_ptr_q];

    assign pop = blk_valid_o && blk_ready_i;
    assign buf_pop = pop && !bypass;
    assign push = pending_q && !(bypass && pop);

    // read only when the returning block has a guaranteed slot
    assign issue = fetching_q && !flush_i && ((occupancy < depth) || pop);

    assign weight_req_o = '{ren: issue, addr: blk_cnt_q};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetching_q <= 1'b0;
            blk_cnt_q <= '0;
            pending_q <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            fetching_q <= 1'b0;
            blk_cnt_q <= '0;
            pending_q <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            pending_q <= issue;
            if (start_i) begin
                fetching_q <= 1'b1;
                blk_cnt_q <= '0;
            end else if (issue) begin
                blk_cnt_q <= blk_cnt_q + 1'b1;
                if (blk_cnt_q == block_addr_t'(num_blocks - 1)) begin
                    fetching_q <= 1'b0;
                end
            end
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_bit'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (buf_pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_bit'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !buf_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push && buf_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= weight_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/row_dot.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "macro_settings.svh"

module row_dot
    import ising_pkg::*;
(
    input  logic [`MACRO_SCALE_BIT-1:0] scale_i,
    input  spin_t                       spin_i,
    input  j_block_t                    blk_i,
    input  h_vec_t                      h_i,
    input  block_addr_t                 base_row_i,
    output energy_t                     partial_o
);

    localparam int par = `MACRO_PARALLELISM;
    localparam int num_spin = `MACRO_NUM_SPIN;

    always_comb begin
        energy_t     field;
        int unsigned row;

        partial_o = '0;
        for (int r = 0; r < par; r++) begin
            row = base_row_i * par + r;
            // scaled bias of this row
            field = energy_t'(scale_i) * energy_t'(h_i[row]);
            for (int j = 0; j < num_spin; j++) begin
                if (spin_i[j]) begin
                    field = field + energy_t'(blk_i[r][j]);
                end else begin
                    field = field - energy_t'(blk_i[r][j]);
                end
            end
            // sigma_i times local field
            if (spin_i[row]) begin
                partial_o = partial_o + field;
            end else begin
                partial_o = partial_o - field;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/energy_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "macro_settings.svh"

module energy_monitor
    import ising_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        flush_i,
    input  logic                        cand_valid_i,
    input  spin_t                       cand_spin_i,
    output logic                        cand_ready_o,
    output logic                        start_fetch_o,
    input  logic                        blk_valid_i,
    input  j_block_t                    blk_i,
    output logic                        blk_ready_o,
    input  h_vec_t                      h_bias_i,
    input  logic [`MACRO_SCALE_BIT-1:0] h_scale_i,
    output logic                        energy_valid_o,
    output energy_t                     energy_o,
    input  logic                        energy_ready_i
);

    localparam int num_blocks = `MACRO_NUM_SPIN / `MACRO_PARALLELISM;

    typedef enum logic [1:0] {
        st_idle,
        st_acc,
        st_hold
    } em_state_e;

    em_state_e   state_q;
    spin_t       spin_q;
    energy_t     acc_q;
    energy_t     partial;
    block_addr_t blk_cnt_q;
    logic        spin_hs;
    logic        blk_hs;
    logic        energy_hs;

    assign cand_ready_o = (state_q == st_idle);
    assign spin_hs = cand_valid_i && cand_ready_o;

    // weight_fetch starts streaming blocks 0.. on this pulse
    assign start_fetch_o = spin_hs;

    assign blk_ready_o = (state_q == st_acc);
    assign blk_hs = blk_valid_i && blk_ready_o;

    assign energy_valid_o = (state_q == st_hold);
    assign energy_hs = energy_valid_o && energy_ready_i;
    assign energy_o = acc_q;

    row_dot u_row_dot (
        .scale_i    (h_scale_i),
        .spin_i     (spin_q),
        .blk_i      (blk_i),
        .h_i        (h_bias_i),
        .base_row_i (blk_cnt_q),
        .partial_o  (partial)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= st_idle;
            blk_cnt_q <= '0;
        end else if (flush_i) begin
            state_q <= st_idle;
            blk_cnt_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (spin_hs) begin
                        state_q <= st_acc;
                        blk_cnt_q <= '0;
                    end
                end
                st_acc: begin
                    if (blk_hs) begin
                        blk_cnt_q <= blk_cnt_q + 1'b1;
                        if (blk_cnt_q == block_addr_t'(num_blocks - 1)) begin
                            state_q <= st_hold;
                        end
                    end
                end
                st_hold: begin
                    if (energy_hs) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // spin and running sum
    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= cand_spin_i;
            acc_q <= '0;
        end else if (blk_hs) begin
            acc_q <= acc_q + partial;
        end
    end

endmodule

`default_nettype wire

// ==== source/flip_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "macro_settings.svh"

module flip_manager
    import ising_pkg::*;
    import mem_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            flush_i,
    input  logic                            config_valid_i,
    input  spin_t                           config_spin_i,
    input  logic                            cmpt_en_i,
    input  logic                            en_comparison_i,
    input  logic [`MACRO_FLIP_ADDR_BIT-1:0] flip_last_addr_i,
    output flip_req_t                       flip_req_o,
    input  flip_rsp_t                       flip_rsp_i,
    output logic                            cand_valid_o,
    output spin_t                           cand_spin_o,
    input  logic                            cand_ready_i,
    input  logic                            energy_valid_i,
    input  energy_t                         energy_i,
    output logic                            energy_ready_o,
    output energy_t                         best_energy_o,
    output spin_t                           best_spin_o,
    output logic                            energy_fifo_update_o,
    output logic                            cmpt_idle_o
);

    typedef enum logic [2:0] {
        st_idle,
        st_send,
        st_wait,
        st_read,
        st_flip
    } fm_state_e;

    fm_state_e  state_q;
    logic       cmpt_en_q;
    logic       cmpt_rise;
    logic       baseline_q;
    logic       update_q;
    logic       accept;
    flip_addr_t iter_q;
    spin_t      cand_q;
    spin_t      cur_spin_q;
    spin_t      best_spin_q;
    energy_t    best_energy_q;

    assign cmpt_rise = cmpt_en_i && !cmpt_en_q;

    // baseline always replaces, otherwise strictly lower or comparison off
    assign accept = baseline_q || !en_comparison_i || (energy_i < best_energy_q);

    assign cand_valid_o = (state_q == st_send);
    assign cand_spin_o = cand_q;
    assign energy_ready_o = (state_q == st_wait);
    assign flip_req_o = '{ren: (state_q == st_read), addr: iter_q};

    assign best_energy_o = best_energy_q;
    assign best_spin_o = best_spin_q;
    assign energy_fifo_update_o = update_q;
    assign cmpt_idle_o = (state_q == st_idle);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= st_idle;
            cmpt_en_q <= 1'b0;
            baseline_q <= 1'b0;
            update_q <= 1'b0;
            iter_q <= '0;
            cur_spin_q <= '0;
            best_spin_q <= '0;
            best_energy_q <= '0;
        end else begin
            cmpt_en_q <= cmpt_en_i;
            update_q <= 1'b0;
            if (config_valid_i) begin
                cur_spin_q <= config_spin_i;
                best_spin_q <= '0;
                best_energy_q <= '0;
            end
            if (flush_i) begin
                state_q <= st_idle;
            end else begin
                case (state_q)
                    st_idle: begin
                        if (cmpt_rise) begin
                            state_q <= st_send;
                            baseline_q <= 1'b1;
                            iter_q <= '0;
                        end
                    end
                    st_send: begin
                        if (cand_ready_i) begin
                            state_q <= st_wait;
                        end
                    end
                    st_wait: begin
                        if (energy_valid_i) begin
                            baseline_q <= 1'b0;
                            if (accept) begin
                                update_q <= 1'b1;
                                best_energy_q <= energy_i;
                                best_spin_q <= cand_q;
                                cur_spin_q <= cand_q;
                            end
                            // iter_q counts masks already applied
                            if (iter_q == flip_last_addr_i) begin
                                state_q <= st_idle;
                            end else begin
                                state_q <= st_read;
                            end
                        end
                    end
                    st_read: state_q <= st_flip;
                    st_flip: begin
                        state_q <= st_send;
                        iter_q <= iter_q + 1'b1;
                    end
                    default: state_q <= st_idle;
                endcase
            end
        end
    end

    // candidate is the configured spins on baseline, else current spins xor mask
    always_ff @(posedge clk_i) begin
        if (state_q == st_idle && cmpt_rise) begin
            cand_q <= cur_spin_q;
        end else if (state_q == st_flip) begin
            cand_q <= cur_spin_q ^ flip_rsp_i.mask;
        end
    end

endmodule

`default_nettype wire

// ==== source/digital_macro.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "macro_settings.svh"

module digital_macro
    import ising_pkg::*;
    import mem_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            flush_i,
    input  logic                            config_valid_i,
    input  spin_t                           config_spin_i,
    input  h_vec_t                          h_bias_i,
    input  logic [`MACRO_SCALE_BIT-1:0]     h_scale_i,
    input  logic [`MACRO_FLIP_ADDR_BIT-1:0] flip_last_addr_i,
    input  logic                            en_comparison_i,
    input  logic                            cmpt_en_i,
    output weight_req_t                     weight_req_o,
    input  j_block_t                        weight_rdata_i,
    output flip_req_t                       flip_req_o,
    input  flip_rsp_t                       flip_rsp_i,
    output energy_t                         best_energy_o,
    output spin_t                           best_spin_o,
    output logic                            energy_fifo_update_o,
    output logic                            cmpt_idle_o
);

    // spin channel
    logic     cand_valid;
    logic     cand_ready;
    spin_t    cand_spin;

    // energy channel
    logic     energy_valid;
    logic     energy_ready;
    energy_t  energy;

    // block channel
    logic     blk_valid;
    logic     blk_ready;
    j_block_t blk;
    logic     start_fetch;

    weight_fetch u_weight_fetch (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .start_i        (start_fetch),
        .weight_req_o   (weight_req_o),
        .weight_rdata_i (weight_rdata_i),
        .blk_valid_o    (blk_valid),
        .blk_ready_i    (blk_ready),
        .blk_o          (blk)
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .cand_valid_i   (cand_valid),
        .cand_spin_i    (cand_spin),
        .cand_ready_o   (cand_ready),
        .start_fetch_o  (start_fetch),
        .blk_valid_i    (blk_valid),
        .blk_i          (blk),
        .blk_ready_o    (blk_ready),
        .h_bias_i       (h_bias_i),
        .h_scale_i      (h_scale_i),
        .energy_valid_o (energy_valid),
        .energy_o       (energy),
        .energy_ready_i (energy_ready)
    );

    flip_manager u_flip_manager (
        .clk_i                (clk_i),
        .arst_n_i             (arst_n_i),
        .flush_i              (flush_i),
        .config_valid_i       (config_valid_i),
        .config_spin_i        (config_spin_i),
        .cmpt_en_i            (cmpt_en_i),
        .en_comparison_i      (en_comparison_i),
        .flip_last_addr_i     (flip_last_addr_i),
        .flip_req_o           (flip_req_o),
        .flip_rsp_i           (flip_rsp_i),
        .cand_valid_o         (cand_valid),
        .cand_spin_o          (cand_spin),
        .cand_ready_i         (cand_ready),
        .energy_valid_i       (energy_valid),
        .energy_i             (energy),
        .energy_ready_o       (energy_ready),
        .best_energy_o        (best_energy_o),
        .best_spin_o          (best_spin_o),
        .energy_fifo_update_o (energy_fifo_update_o),
        .cmpt_idle_o          (cmpt_idle_o)
    );

endmodule

`default_nettype wire

// ==== verification/digital_macro_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module digital_macro_chk
    import ising_pkg::*;
    import mem_pkg::*;
(
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        flush_i,
    input logic        cmpt_en_i,
    input weight_req_t weight_req_o,
    input flip_req_t   flip_req_o,
    input logic        energy_fifo_update_o,
    input logic        cmpt_idle_o
);

    int unsigned failures = 0;

    // no memory reads while in reset
    ren_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (!weight_req_o.ren && !flip_req_o.ren))
        else begin
            failures++;
            $error("memory read issued during reset");
        end

    // update strobe is a single cycle
    update_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        energy_fifo_update_o |=> !energy_fifo_update_o)
        else begin
            failures++;
            $error("energy_fifo_update_o held longer than one cycle");
        end

    // a start edge while idle begins a run
    run_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ($rose(cmpt_en_i) && cmpt_idle_o && !flush_i) |=> !cmpt_idle_o)
        else begin
            failures++;
            $error("cmpt_idle_o stayed high after a start edge");
        end

endmodule

`default_nettype wire

// ==== verification/tb_digital_macro.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "macro_settings.svh"

module tb_digital_macro
    import ising_pkg::*;
    import mem_pkg::*;
();

    localparam int num_spin = `MACRO_NUM_SPIN;
    localparam int par = `MACRO_PARALLELISM;
    localparam int num_blocks = `MACRO_NUM_SPIN / `MACRO_PARALLELISM;
    localparam int flip_depth = 2 ** `MACRO_FLIP_ADDR_BIT;
    localparam int timeout_cycles = 5000;
    localparam int flush_timeout_cycles = 4;

    logic                        clk;
    logic                        arst_n;
    logic                        flush;
    logic                        config_valid;
    spin_t                       config_spin;
    h_vec_t                      h_bias;
    logic [`MACRO_SCALE_BIT-1:0] h_scale;
    flip_addr_t                  flip_last_addr;
    logic                        en_comparison;
    logic                        cmpt_en;
    weight_req_t                 weight_req;
    j_block_t                    weight_rdata;
    flip_req_t                   flip_req;
    flip_rsp_t                   flip_rsp;
    energy_t                     best_energy;
    spin_t                       best_spin;
    logic                        update;
    logic                        idle;

    // memory contents and reference model state
    j_block_t    w_mem [num_blocks];
    spin_t       flip_mem [flip_depth];
    int          j_mat [num_spin][num_spin];
    int          h_mod [num_spin];
    int          scale_mod;
    logic        w_ren_q = 1'b0;
    block_addr_t w_addr_q;
    logic        f_ren_q = 1'b0;
    flip_addr_t  f_addr_q;
    int          pulse_cnt = 0;
    int          seed;
    int          errors;
    int          tests;
    int          failed_tests;
    bit          timed_out;

    digital_macro u_digital_macro (
        .clk_i                (clk),
        .arst_n_i             (arst_n),
        .flush_i              (flush),
        .config_valid_i       (config_valid),
        .config_spin_i        (config_spin),
        .h_bias_i             (h_bias),
        .h_scale_i            (h_scale),
        .flip_last_addr_i     (flip_last_addr),
        .en_comparison_i      (en_comparison),
        .cmpt_en_i            (cmpt_en),
        .weight_req_o         (weight_req),
        .weight_rdata_i       (weight_rdata),
        .flip_req_o           (flip_req),
        .flip_rsp_i           (flip_rsp),
        .best_energy_o        (best_energy),
        .best_spin_o          (best_spin),
        .energy_fifo_update_o (update),
        .cmpt_idle_o          (idle)
    );

    bind digital_macro digital_macro_chk u_digital_macro_chk (.*);

    always #50 clk = ~clk;

    // both memories answer in the cycle after ren
    always @(posedge clk) begin
        w_ren_q <= weight_req.ren;
        w_addr_q <= weight_req.addr;
        f_ren_q <= flip_req.ren;
        f_addr_q <= flip_req.addr;
    end

    always @(negedge clk) begin
        if (w_ren_q) begin
            weight_rdata <= w_mem[w_addr_q];
        end
        if (f_ren_q) begin
            flip_rsp <= '{mask: flip_mem[f_addr_q]};
        end
    end

    always @(posedge clk) begin
        if (update === 1'b1) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    // E = sum_i s_i * (sum_j J_ij s_j + scale * h_i)
    function automatic int ising_energy(input spin_t s);
        int e;
        int field;

        e = 0;
        for (int i = 0; i < num_spin; i++) begin
            field = scale_mod * h_mod[i];
            for (int j = 0; j < num_spin; j++) begin
                field = field + j_mat[i][j] * (s[j] ? 1 : -1);
            end
            e = e + (s[i] ? field : -field);
        end
        return e;
    endfunction

    task automatic wait_idle(input string what, input int limit);
        int cycles;

        cycles = 0;
        while (!idle && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!idle) begin
            $display("timeout: cmpt_idle_o never rose during %s", what);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_result(input string name, input int err_before);
        tests++;
        if (errors == err_before && !timed_out) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    // random couplings, biases, masks and start spins, then a config pulse
    task automatic load_problem(input int n_masks);
        weight_t w;

        for (int i = 0; i < num_spin; i++) begin
            for (int j = 0; j < num_spin; j++) begin
                w = $random(seed);
                j_mat[i][j] = w;
                w_mem[i / par][i % par][j] = w;
            end
            w = $random(seed);
            h_mod[i] = w;
            h_bias[i] = w;
        end
        h_scale = $random(seed);
        scale_mod = h_scale;
        for (int k = 0; k < n_masks; k++) begin
            flip_mem[k] = $random(seed);
        end
        config_spin = $random(seed);
        config_valid = 1'b1;
        @(negedge clk);
        config_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_and_check(input string name, input bit cmp, input int n_masks);
        int    exp_energy;
        int    exp_pulses;
        int    e;
        int    pulses_before;
        int    err_before;
        spin_t cur;
        spin_t cand;
        spin_t exp_spin;

        if (timed_out) begin
            return;
        end
        cur = config_spin;
        exp_spin = cur;
        exp_energy = ising_energy(cur);
        exp_pulses = 1;
        for (int k = 0; k < n_masks; k++) begin
            cand = cur ^ flip_mem[k];
            e = ising_energy(cand);
            if (!cmp || e < exp_energy) begin
                exp_energy = e;
                exp_spin = cand;
                cur = cand;
                exp_pulses++;
            end
        end

        err_before = errors;
        pulses_before = pulse_cnt;
        en_comparison = cmp;
        flip_last_addr = flip_addr_t'(n_masks);
        cmpt_en = 1'b1;
        @(negedge clk);
        wait_idle(name, timeout_cycles);
        // last update pulse gets counted on the next edge
        @(negedge clk);
        cmpt_en = 1'b0;
        if (!timed_out) begin
            if (best_energy !== energy_t'(exp_energy)) begin
                $display("[ERROR] %0t best_energy_o: got %0d, expected %0d",
                         $time, best_energy, exp_energy);
                errors++;
            end
            if (best_spin !== exp_spin) begin
                $display("[ERROR] %0t best_spin_o: got %h, expected %h",
                         $time, best_spin, exp_spin);
                errors++;
            end
            if (pulse_cnt - pulses_before != exp_pulses) begin
                $display("[ERROR] %0t energy_fifo_update_o pulses: got %0d, expected %0d",
                         $time, pulse_cnt - pulses_before, exp_pulses);
                errors++;
            end
        end
        report_result(name, err_before);
    endtask

    task automatic flush_mid_run(input int stall);
        int err_before;

        if (timed_out) begin
            return;
        end
        err_before = errors;
        en_comparison = 1'b1;
        flip_last_addr = flip_addr_t'(flip_depth - 1);
        cmpt_en = 1'b1;
        repeat (stall) @(negedge clk);
        if (idle) begin
            $display("run finished before the flush was applied");
            errors++;
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // a long run still in progress, so only the flush can end it this soon
        wait_idle("flush", flush_timeout_cycles);
        cmpt_en = 1'b0;
        @(negedge clk);
        report_result("flush during run", err_before);
    endtask

    initial begin
        int n;

        clk = 1'b0;
        arst_n = 1'b1;
        flush = 1'b0;
        config_valid = 1'b0;
        config_spin = '0;
        h_bias = '0;
        h_scale = '0;
        flip_last_addr = '0;
        en_comparison = 1'b0;
        cmpt_en = 1'b0;
        weight_rdata = '0;
        flip_rsp = '0;
        seed = 32'h991d;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        // clean falling edge on reset
        #1 arst_n = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        load_problem(0);
        run_and_check("baseline, comparison on", 1'b1, 0);
        load_problem(0);
        run_and_check("baseline, comparison off", 1'b0, 0);
        for (int r = 0; r < 4; r++) begin
            n = 1 + ($unsigned($random(seed)) % 12);
            load_problem(n);
            run_and_check($sformatf("greedy run %0d with %0d masks", r, n), 1'b1, n);
        end
        for (int r = 0; r < 3; r++) begin
            n = 1 + ($unsigned($random(seed)) % 12);
            load_problem(n);
            run_and_check($sformatf("no comparison run %0d with %0d masks", r, n), 1'b0, n);
        end
        load_problem(flip_depth - 1);
        flush_mid_run(10 + ($unsigned($random(seed)) % 50));
        load_problem(8);
        run_and_check("run after flush", 1'b1, 8);

        errors = errors + u_digital_macro.u_digital_macro_chk.failures;
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/ising_pkg.sv
source/mem_pkg.sv
source/weight_fetch.sv
source/row_dot.sv
source/energy_monitor.sv
source/flip_manager.sv
source/digital_macro.sv
verification/digital_macro_chk.sv
verification/tb_digital_macro.sv

// ==== Bender.yml ====
package:
  name: digital_macro

sources:
  - include_dirs:
      - source
    files:
      - source/ising_pkg.sv
      - source/mem_pkg.sv
      - source/weight_fetch.sv
      - source/row_dot.sv
      - source/energy_monitor.sv
      - source/flip_manager.sv
      - source/digital_macro.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/digital_macro_chk.sv
      - verification/tb_digital_macro.sv
